//--- trig_pkg.sv
package trig_pkg;

    // upper bound on the channel count, also the width of every per-channel mask
    localparam int MAX_CHAN = 16;

    // width of one trigger word as it arrives from a channel
    localparam int TRIG_WORD_BITS = 16;

    // the bottom bits of a trigger word carry no address information
    localparam int ADDR_LSB = 2;

    // one trigger word: valid flag on top, then the address field, then the skipped bits
    typedef struct packed {
        logic                                 valid;
        logic [TRIG_WORD_BITS-ADDR_LSB-2:0]   addr;
        logic [ADDR_LSB-1:0]                  rsvd;
    } trig_word_t;

    // one readout event: which channels hit, and at which ring address
    typedef struct packed {
        logic [MAX_CHAN-1:0] hit_mask;
        logic [15:0]         addr;
    } trig_event_t;

    // run state as seen by the channels, the registers and the testbench
    typedef enum logic [1:0] {
        RUN_CLEAR   = 2'd0,
        RUN_IDLE    = 2'd1,
        RUN_FILL    = 2'd2,
        RUN_READOUT = 2'd3
    } run_state_e;

    // configuration held in the register block
    typedef struct packed {
        logic [MAX_CHAN-1:0] mask;
        logic [15:0]         latency;
    } trig_cfg_t;

    // APB byte offsets of the registers
    typedef enum logic [7:0] {
        REG_MASK    = 8'h00,
        REG_LATENCY = 8'h04,
        REG_STATUS  = 8'h08
    } reg_addr_e;

    // everything masked until software says otherwise
    localparam logic [MAX_CHAN-1:0] MASK_RESET = '1;

    // maximum latency so that any sane programmed value is shorter
    localparam logic [15:0] LATENCY_RESET = '1;

    // triggers are accepted and time advances only in these two states
    function automatic logic run_active(run_state_e state);
        return (state == RUN_FILL) || (state == RUN_READOUT);
    endfunction

endpackage

//--- trig_cfg_regs.sv
module trig_cfg_regs #(
    parameter int NCHAN = 8
) (
    input  logic                    sysclk_i,
    input  logic                    runrst_i,
    input  logic                    psel_i,
    input  logic                    penable_i,
    input  logic                    pwrite_i,
    input  logic [7:0]              paddr_i,
    input  logic [31:0]             pwdata_i,
    output logic [31:0]             prdata_o,
    output logic                    pready_o,
    output logic                    pslverr_o,
    input  trig_pkg::run_state_e    run_state_i,
    input  logic [15:0]             drop_count_i,
    output trig_pkg::trig_cfg_t     cfg_o
);

    // only the bits of channels that exist can be stored
    localparam logic [15:0] CHAN_BITS = 16'((32'd1 << NCHAN) - 32'd1);

    trig_pkg::trig_cfg_t cfg_q;

    logic access;
    logic known_addr;
    logic wr_mask;
    logic wr_latency;
    logic bad_write;

    // the access phase is the second cycle of every APB transfer
    assign access = psel_i && penable_i;

    // offset decode, the status register is read-only
    always_comb begin
        known_addr = 1'b0;
        wr_mask    = 1'b0;
        wr_latency = 1'b0;
        bad_write  = 1'b0;
        case (paddr_i)
            trig_pkg::REG_MASK: begin
                known_addr = 1'b1;
                wr_mask    = access && pwrite_i;
            end
            trig_pkg::REG_LATENCY: begin
                known_addr = 1'b1;
                wr_latency = access && pwrite_i;
            end
            trig_pkg::REG_STATUS: begin
                known_addr = 1'b1;
                bad_write  = pwrite_i;
            end
            default: begin
                known_addr = 1'b0;
            end
        endcase
    end

    always_ff @(posedge sysclk_i) begin
        if (runrst_i) begin
            cfg_q.mask    <= trig_pkg::MASK_RESET & CHAN_BITS;
            cfg_q.latency <= trig_pkg::LATENCY_RESET;
        end else begin
            // mask bits of missing channels are dropped on the way in
            if (wr_mask) begin
                cfg_q.mask <= pwdata_i[15:0] & CHAN_BITS;
            end
            if (wr_latency) begin
                cfg_q.latency <= pwdata_i[15:0];
            end
        end
    end

    // read data is combinational and valid during the access phase
    always_comb begin
        case (paddr_i)
            trig_pkg::REG_MASK:    prdata_o = {16'd0, cfg_q.mask};
            trig_pkg::REG_LATENCY: prdata_o = {16'd0, cfg_q.latency};
            trig_pkg::REG_STATUS:  prdata_o = {drop_count_i, 14'd0, run_state_i};
            default:               prdata_o = 32'd0;
        endcase
    end

    // no wait states, every access completes in its first access cycle
    assign pready_o = 1'b1;

    // unknown offsets and writes to the status word are refused
    assign pslverr_o = access && (!known_addr || bad_write);

    assign cfg_o = cfg_q;

    // the write strobes rely on every access phase following a setup phase to the same offset
    a_access_after_setup: assert property (
        @(posedge sysclk_i) disable iff (runrst_i)
        psel_i && penable_i |-> $past(psel_i && !penable_i) && $stable(paddr_i)
    );

endmodule

//--- trig_run_ctrl.sv
module trig_run_ctrl #(
    parameter int ADDRBITS = 8
) (
    input  logic                    sysclk_i,
    input  logic                    runrst_i,
    input  logic                    run_start_i,
    input  logic                    run_stop_i,
    input  logic [15:0]             latency_i,
    output trig_pkg::run_state_e    state_o,
    output logic [ADDRBITS-1:0]     write_time_o,
    output logic [ADDRBITS-1:0]     rd_addr_o,
    output logic                    rd_en_o
);

    localparam logic [ADDRBITS-1:0] SWEEP_LAST = '1;

    trig_pkg::run_state_e state_q;
    trig_pkg::run_state_e state_d;

    logic [ADDRBITS-1:0] sweep_q;
    logic [ADDRBITS-1:0] wtime_q;
    logic [ADDRBITS-1:0] rd_ptr_q;
    logic [15:0]         lat_q;
    logic [15:0]         lat_cnt_q;

    // next state, start and stop are only honoured in the states that expect them
    always_comb begin
        state_d = state_q;
        case (state_q)
            trig_pkg::RUN_CLEAR: begin
                // the last sweep address has been cleared this cycle
                if (sweep_q == SWEEP_LAST) begin
                    state_d = trig_pkg::RUN_IDLE;
                end
            end
            trig_pkg::RUN_IDLE: begin
                if (run_start_i) begin
                    state_d = trig_pkg::RUN_FILL;
                end
            end
            trig_pkg::RUN_FILL: begin
                if (run_stop_i) begin
                    state_d = trig_pkg::RUN_CLEAR;
                end else if (lat_cnt_q == lat_q) begin
                    state_d = trig_pkg::RUN_READOUT;
                end
            end
            trig_pkg::RUN_READOUT: begin
                if (run_stop_i) begin
                    state_d = trig_pkg::RUN_CLEAR;
                end
            end
            default: begin
                state_d = trig_pkg::RUN_CLEAR;
            end
        endcase
    end

    always_ff @(posedge sysclk_i) begin
        if (runrst_i) begin
            state_q   <= trig_pkg::RUN_CLEAR;
            sweep_q   <= '0;
            wtime_q   <= '0;
            rd_ptr_q  <= '0;
            lat_q     <= trig_pkg::LATENCY_RESET;
            lat_cnt_q <= '0;
        end else begin
            state_q <= state_d;

            // the sweep walks every address once per visit to RUN_CLEAR
            sweep_q <= (state_q == trig_pkg::RUN_CLEAR) ? sweep_q + 1'b1 : '0;

            // write time is zero in the first fill cycle and wraps with the ring
            if (trig_pkg::run_active(state_q) && trig_pkg::run_active(state_d)) begin
                wtime_q <= wtime_q + 1'b1;
            end else begin
                wtime_q <= '0;
            end

            // latency is frozen for the whole run
            if (state_q == trig_pkg::RUN_IDLE && run_start_i) begin
                lat_q <= latency_i;
            end

            // counts the fill cycles spent so far
            lat_cnt_q <= (state_q == trig_pkg::RUN_FILL) ? lat_cnt_q + 1'b1 : '0;

            // readout pointer starts at address 0 and returns there on stop
            if (state_q == trig_pkg::RUN_READOUT) begin
                rd_ptr_q <= run_stop_i ? '0 : rd_ptr_q + 1'b1;
            end
        end
    end

    // the sweep and the readout share one read port into the channels
    assign rd_addr_o = (state_q == trig_pkg::RUN_CLEAR) ? sweep_q : rd_ptr_q;
    assign rd_en_o   = (state_q == trig_pkg::RUN_CLEAR) || (state_q == trig_pkg::RUN_READOUT);

    assign state_o      = state_q;
    assign write_time_o = wtime_q;

    // while reading out, the pointer trails the write time by exactly the latency plus one
    a_ptr_trails_wtime: assert property (
        @(posedge sysclk_i) disable iff (runrst_i)
        state_q == trig_pkg::RUN_READOUT |->
            rd_ptr_q == ADDRBITS'(wtime_q - lat_q[ADDRBITS-1:0] - 1'b1)
    );

    // readout is reached only after the latency has expired in fill
    a_readout_from_fill: assert property (
        @(posedge sysclk_i) disable iff (runrst_i)
        $rose(state_q == trig_pkg::RUN_READOUT) |-> $past(state_q) == trig_pkg::RUN_FILL
    );

endmodule

//--- trig_channel.sv
module trig_channel #(
    parameter int ADDRBITS = 8
) (
    input  logic                    sysclk_i,
    input  logic                    runrst_i,
    input  trig_pkg::trig_word_t    word_i,
    input  logic                    strobe_i,
    input  logic                    mask_i,
    input  trig_pkg::run_state_e    state_i,
    input  logic [ADDRBITS-1:0]     rd_addr_i,
    input  logic                    rd_en_i,
    output logic                    hit_o
);

    localparam int DEPTH = 1 << ADDRBITS;

    // one hit bit per ring address
    logic [DEPTH-1:0] mem_q;

    logic                capture;
    logic                wr_en_q;
    logic [ADDRBITS-1:0] wr_addr_q;
    logic                hit_q;

    // a new, valid and unmasked word is taken only while a run is active
    assign capture = strobe_i && word_i.valid && !mask_i && trig_pkg::run_active(state_i);

    always_ff @(posedge sysclk_i) begin
        if (runrst_i) begin
            wr_en_q <= 1'b0;
            hit_q   <= 1'b0;
        end else begin
            wr_en_q <= capture;
            // the read result is only meaningful the cycle after a strobe
            hit_q   <= rd_en_i && mem_q[rd_addr_i];
        end
    end

    // the address field above the skipped bits selects the ring slot
    always_ff @(posedge sysclk_i) begin
        if (capture) begin
            wr_addr_q <= word_i.addr[ADDRBITS-1:0];
        end
    end

    // clear on read first, so a write to the same bit in the same cycle wins
    always_ff @(posedge sysclk_i) begin
        if (rd_en_i) begin
            mem_q[rd_addr_i] <= 1'b0;
        end
        // a write still in flight when the run stops would outlive the sweep
        if (wr_en_q && trig_pkg::run_active(state_i)) begin
            mem_q[wr_addr_q] <= 1'b1;
        end
    end

    assign hit_o = hit_q;

endmodule

//--- trig_event_fifo.sv
module trig_event_fifo #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                    sysclk_i,
    input  logic                    runrst_i,
    input  logic                    flush_i,
    input  logic                    push_i,
    input  trig_pkg::trig_event_t   event_i,
    output trig_pkg::trig_event_t   event_o,
    output logic                    event_valid_o,
    input  logic                    event_ready_i,
    input  logic                    clr_drops_i,
    output logic [15:0]             drop_count_o
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);
    localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(FIFO_DEPTH - 1);
    localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(FIFO_DEPTH);

    trig_pkg::trig_event_t mem_q [FIFO_DEPTH];

    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic [15:0]      drops_q;

    logic full;
    logic pop;
    logic wr_ok;
    logic drop;

    assign full  = (count_q == CNT_FULL);
    assign pop   = event_valid_o && event_ready_i;
    assign wr_ok = push_i && !full;
    // a flushed push is discarded on purpose and is not counted as lost
    assign drop  = push_i && full && !flush_i;

    always_ff @(posedge sysclk_i) begin
        if (runrst_i || flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (wr_ok) begin
                wr_ptr_q <= (wr_ptr_q == PTR_LAST) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_LAST) ? '0 : rd_ptr_q + 1'b1;
            end
            // occupancy moves only when exactly one side is active
            case ({wr_ok, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge sysclk_i) begin
        if (wr_ok) begin
            mem_q[wr_ptr_q] <= event_i;
        end
    end

    // saturating count of events that found the FIFO full
    always_ff @(posedge sysclk_i) begin
        if (runrst_i || clr_drops_i) begin
            drops_q <= '0;
        end else if (drop && drops_q != 16'hffff) begin
            drops_q <= drops_q + 1'b1;
        end
    end

    // the head is shown for as long as the FIFO is not empty
    assign event_o       = mem_q[rd_ptr_q];
    assign event_valid_o = (count_q != '0);
    assign drop_count_o  = drops_q;

    a_occupancy_bound: assert property (
        @(posedge sysclk_i) disable iff (runrst_i)
        count_q <= CNT_FULL
    );

endmodule

//--- trig_process_top.sv
module trig_process_top #(
    parameter int NCHAN      = 8,
    parameter int ADDRBITS   = 8,
    parameter int FIFO_DEPTH = 8
) (
    input  logic                                sysclk_i,
    input  logic                                runrst_i,
    input  logic                                run_start_i,
    input  logic                                run_stop_i,
    input  logic                                trig_strobe_i,
    input  trig_pkg::trig_word_t [NCHAN-1:0]    trig_word_i,
    input  logic                                psel_i,
    input  logic                                penable_i,
    input  logic                                pwrite_i,
    input  logic [7:0]                          paddr_i,
    input  logic [31:0]                         pwdata_i,
    output logic [31:0]                         prdata_o,
    output logic                                pready_o,
    output logic                                pslverr_o,
    output trig_pkg::trig_event_t               event_o,
    output logic                                event_valid_o,
    input  logic                                event_ready_i,
    output logic                                running_o,
    output logic [ADDRBITS-1:0]                 write_time_o
);

    trig_pkg::trig_cfg_t   cfg;
    trig_pkg::run_state_e  run_state;
    trig_pkg::trig_event_t new_event;

    logic [ADDRBITS-1:0] rd_addr;
    logic                rd_en;
    logic [NCHAN-1:0]    hit_w;
    logic [ADDRBITS-1:0] rd_addr_q;
    logic                sweep_q;
    logic [15:0]         drop_count;
    logic                run_start_ok;
    logic                push;

    trig_cfg_regs #(.NCHAN(NCHAN)) u_regs (
        .sysclk_i, .runrst_i, .psel_i, .penable_i, .pwrite_i, .paddr_i, .pwdata_i,
        .prdata_o, .pready_o, .pslverr_o,
        .run_state_i  (run_state),
        .drop_count_i (drop_count),
        .cfg_o        (cfg)
    );

    trig_run_ctrl #(.ADDRBITS(ADDRBITS)) u_ctrl (
        .sysclk_i, .runrst_i, .run_start_i, .run_stop_i,
        .latency_i    (cfg.latency),
        .state_o      (run_state),
        .write_time_o (write_time_o),
        .rd_addr_o    (rd_addr),
        .rd_en_o      (rd_en)
    );

    // every channel sees the same read port and its own mask bit
    for (genvar ch = 0; ch < NCHAN; ch++) begin : g_chan
        trig_channel #(.ADDRBITS(ADDRBITS)) u_chan (
            .sysclk_i, .runrst_i,
            .word_i    (trig_word_i[ch]),
            .strobe_i  (trig_strobe_i),
            .mask_i    (cfg.mask[ch]),
            .state_i   (run_state),
            .rd_addr_i (rd_addr),
            .rd_en_i   (rd_en),
            .hit_o     (hit_w[ch])
        );
    end

    // the hit bits come back one cycle after the read, so the address follows them
    always_ff @(posedge sysclk_i) begin
        rd_addr_q <= rd_addr;
    end

    // results read during the sweep are stale and never become events
    always_ff @(posedge sysclk_i) begin
        if (runrst_i) begin
            sweep_q <= 1'b1;
        end else begin
            sweep_q <= (run_state == trig_pkg::RUN_CLEAR);
        end
    end

    always_comb begin
        new_event                       = '0;
        new_event.hit_mask[NCHAN-1:0]   = hit_w;
        new_event.addr[ADDRBITS-1:0]    = rd_addr_q;
    end

    assign push         = (|hit_w) && !sweep_q;
    assign run_start_ok = run_start_i && (run_state == trig_pkg::RUN_IDLE);

    trig_event_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
        .sysclk_i, .runrst_i,
        .flush_i       (run_state == trig_pkg::RUN_CLEAR),
        .push_i        (push),
        .event_i       (new_event),
        .event_o       (event_o),
        .event_valid_o (event_valid_o),
        .event_ready_i (event_ready_i),
        .clr_drops_i   (run_start_ok),
        .drop_count_o  (drop_count)
    );

    assign running_o = trig_pkg::run_active(run_state);

endmodule

//--- trig_tb_tasks.svh
// ends the run at the first failed check
task automatic abort_run();
    fail_count++;
    $display("** FAIL **");
    $fatal(1, "simulation stopped at the first error");
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
        $display("CHECK FAILED %s expected %b actual %b", name, exp, act);
        abort_run();
    end
endtask

task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
        $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
        abort_run();
    end
endtask

task automatic check_state(input string name, input trig_pkg::run_state_e exp,
                           input trig_pkg::run_state_e act);
    if (act !== exp) begin
        $display("CHECK FAILED %s expected %s actual %s", name, exp.name(), act.name());
        abort_run();
    end
endtask

task automatic check_event(input string name, input trig_pkg::trig_event_t exp,
                           input trig_pkg::trig_event_t act);
    if (act !== exp) begin
        $display("CHECK FAILED %s expected hits %h addr %h actual hits %h addr %h",
                 name, exp.hit_mask, exp.addr, act.hit_mask, act.addr);
        abort_run();
    end
endtask

// one APB transfer, a setup cycle then a single access cycle
task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                          output logic [31:0] rdata, output logic err);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(posedge sysclk);
    #2;
    penable = 1'b1;
    // the slave answers combinationally, so look in the middle of the access cycle
    @(negedge sysclk);
    check_bit("pready in access phase", 1'b1, pready);
    rdata = prdata;
    err   = pslverr;
    @(posedge sysclk);
    #2;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
endtask

task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, output logic err);
    logic [31:0] unused;
    apb_access(1'b1, addr, data, unused, err);
endtask

task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, output logic err);
    apb_access(1'b0, addr, 32'd0, data, err);
endtask

// polls the status register, every poll costs two cycles
task automatic wait_state(input trig_pkg::run_state_e target, input int max_cycles);
    logic [31:0] status;
    logic        err;
    int          waited;
    waited = 0;
    apb_read(trig_pkg::REG_STATUS, status, err);
    while (trig_pkg::run_state_e'(status[1:0]) != target) begin
        waited += 2;
        if (waited > max_cycles) begin
            $display("timeout while waiting for run state %s", target.name());
            abort_run();
        end
        apb_read(trig_pkg::REG_STATUS, status, err);
    end
endtask

task automatic wait_cycle(input int target, input int max_cycles);
    int waited;
    waited = 0;
    while (cycle_count < target) begin
        if (waited > max_cycles) begin
            $display("timeout while waiting for cycle %0d", target);
            abort_run();
        end
        @(posedge sysclk);
        #2;
        waited++;
    end
endtask

// returns the event taken in the next cycle where valid and ready are both high
task automatic wait_event(input int max_cycles, output trig_pkg::trig_event_t ev);
    int waited;
    waited = 0;
    @(negedge sysclk);
    while (!(event_valid && event_ready)) begin
        waited++;
        if (waited > max_cycles) begin
            $display("timeout while waiting for an accepted output event");
            abort_run();
        end
        @(negedge sysclk);
    end
    ev = event_out;
    @(posedge sysclk);
    #2;
endtask

//--- trig_process_tb.sv
module trig_process_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NCHAN      = 8;
    localparam int ADDRBITS   = 8;
    localparam int FIFO_DEPTH = 8;
    localparam int RING       = 1 << ADDRBITS;
    localparam int NROWS      = 4;
    localparam int MAX_ENT    = 11;
    localparam logic [15:0] CHAN_ONES = 16'((1 << NCHAN) - 1);

    logic                             sysclk;
    logic                             runrst;
    logic                             run_start;
    logic                             run_stop;
    logic                             trig_strobe;
    trig_pkg::trig_word_t [NCHAN-1:0] trig_word;
    logic                             psel;
    logic                             penable;
    logic                             pwrite;
    logic [7:0]                       paddr;
    logic [31:0]                      pwdata;
    logic [31:0]                      prdata;
    logic                             pready;
    logic                             pslverr;
    trig_pkg::trig_event_t            event_out;
    logic                             event_valid;
    logic                             event_ready;
    logic                             running;
    logic [ADDRBITS-1:0]              write_time;

    int          cycle_count = 0;
    int          fail_count = 0;
    int          fill_start;
    int          last_addr;
    integer      rand_seed = 32'h862c43a3;
    logic [7:0]  ready_pat = 8'hff;
    logic        ready_hold = 1'b1;
    // expected hit mask per ring address, built from the triggers that were sent
    logic [15:0] exp_hits [RING];

    // each entry is a channel set in bits 23:8 and an offset from write_time in bits 7:0
    string       row_name    [NROWS] = '{"grouping", "order", "backpressure", "restart"};
    logic [15:0] row_mask    [NROWS] = '{16'h0012, 16'h0000, 16'h0000, 16'h0080};
    logic [15:0] row_lat     [NROWS] = '{16'd40, 16'd64, 16'd48, 16'd32};
    logic [7:0]  row_ready   [NROWS] = '{8'hff, 8'b1011_0110, 8'hff, 8'b0110_1101};
    logic        row_hold    [NROWS] = '{1'b0, 1'b0, 1'b1, 1'b0};
    logic        row_restart [NROWS] = '{1'b0, 1'b0, 1'b0, 1'b1};
    int          row_nrand   [NROWS] = '{0, 4, 2, 0};
    int          row_nent    [NROWS] = '{4, 5, 11, 2};
    logic [23:0] row_fresh   [NROWS] = '{24'h0, 24'h0, 24'h0, 24'h00c314};
    logic [23:0] row_ent     [NROWS][MAX_ENT] = '{
        '{24'h00f306, 24'h00100c, 24'h002114, 24'h000c03, 24'h0, 24'h0, 24'h0, 24'h0,
          24'h0, 24'h0, 24'h0},
        '{24'h00011e, 24'h000203, 24'h008011, 24'h004409, 24'h00031e, 24'h0, 24'h0,
          24'h0, 24'h0, 24'h0, 24'h0},
        '{24'h00010a, 24'h00020a, 24'h00040a, 24'h00080a, 24'h00100a, 24'h00200a,
          24'h00400a, 24'h00800a, 24'h00030a, 24'h000c0a, 24'h00f00a},
        '{24'h000f04, 24'h003008, 24'h0, 24'h0, 24'h0, 24'h0, 24'h0, 24'h0, 24'h0,
          24'h0, 24'h0}
    };

    `include "trig_tb_tasks.svh"

    trig_process_top uut (
        .sysclk_i      (sysclk),
        .runrst_i      (runrst),
        .run_start_i   (run_start),
        .run_stop_i    (run_stop),
        .trig_strobe_i (trig_strobe),
        .trig_word_i   (trig_word),
        .psel_i        (psel),
        .penable_i     (penable),
        .pwrite_i      (pwrite),
        .paddr_i       (paddr),
        .pwdata_i      (pwdata),
        .prdata_o      (prdata),
        .pready_o      (pready),
        .pslverr_o     (pslverr),
        .event_o       (event_out),
        .event_valid_o (event_valid),
        .event_ready_i (event_ready),
        .running_o     (running),
        .write_time_o  (write_time)
    );

    initial begin
        sysclk = 1'b0;
        forever #20 sysclk = ~sysclk;
    end

    always @(posedge sysclk) begin
        cycle_count <= cycle_count + 1;
    end

    // output ready follows the row pattern unless it is held low
    initial begin
        forever begin
            @(posedge sysclk);
            #2;
            event_ready = !ready_hold && ready_pat[cycle_count % 8];
        end
    end

    // ready controls change mid-cycle so the driver never sees them mid-update
    task automatic set_ready(input logic [7:0] pat, input logic hold);
        @(negedge sysclk);
        ready_pat  = pat;
        ready_hold = hold;
        @(posedge sysclk);
        #2;
    endtask

    // the address is the current write time plus the offset, as the channel sees it
    task automatic place_trigger(input logic [15:0] chans, input int off, input logic [15:0] mask);
        int a;
        // write time counts the fill cycles from zero and wraps with the ring
        check_word("write time at trigger", 32'((cycle_count - fill_start) % RING),
                   32'(write_time));
        a = (int'(write_time) + off) % RING;
        for (int ch = 0; ch < NCHAN; ch++) begin
            trig_word[ch].valid = chans[ch];
            trig_word[ch].addr  = 13'(a);
            trig_word[ch].rsvd  = 2'b11;
        end
        trig_strobe = 1'b1;
        // masked channels and channels beyond NCHAN must never show up in a hit mask
        exp_hits[a] = exp_hits[a] | (chans & ~mask & CHAN_ONES);
        if (a > last_addr) begin
            last_addr = a;
        end
        @(posedge sysclk);
        #2;
        trig_strobe = 1'b0;
        trig_word   = '0;
    endtask

    task automatic start_run();
        run_start = 1'b1;
        @(posedge sysclk);
        #2;
        run_start  = 1'b0;
        fill_start = cycle_count;
        check_bit("running at run start", 1'b1, running);
        check_word("write time in first fill cycle", 32'd0, 32'(write_time));
    endtask

    task automatic stop_run();
        run_stop = 1'b1;
        @(posedge sysclk);
        #2;
        run_stop = 1'b0;
        check_bit("running after stop", 1'b0, running);
        wait_state(trig_pkg::RUN_IDLE, RING + 10);
        check_bit("event valid after flush", 1'b0, event_valid);
    endtask

    task automatic clear_expected();
        for (int a = 0; a < RING; a++) begin
            exp_hits[a] = '0;
        end
        last_addr = 0;
    endtask

    task automatic run_row(input int r);
        trig_pkg::trig_event_t exp_q [$];
        trig_pkg::trig_event_t ev;
        logic [31:0]           rd;
        logic [31:0]           rnd;
        logic                  err;
        int                    lim;
        int                    drops;
        int                    n_take;
        int                    done_cycle;
        apb_write(trig_pkg::REG_MASK, {16'd0, row_mask[r]}, err);
        check_bit({row_name[r], " mask write error"}, 1'b0, err);
        apb_write(trig_pkg::REG_LATENCY, {16'd0, row_lat[r]}, err);
        check_bit({row_name[r], " latency write error"}, 1'b0, err);
        set_ready(row_ready[r], row_hold[r]);
        lim = (row_lat[r] - 4 < 32) ? int'(row_lat[r]) - 4 : 32;
        clear_expected();
        start_run();
        for (int k = 0; k < row_nent[r]; k++) begin
            place_trigger(row_ent[r][k][23:8], int'(row_ent[r][k][7:0]), row_mask[r]);
            check_bit({row_name[r], " running in fill"}, 1'b1, running);
        end
        for (int k = 0; k < row_nrand[r]; k++) begin
            rnd = $random(rand_seed);
            place_trigger(16'(rnd[NCHAN-1:0]), int'({16'd0, rnd[31:16]}) % lim, row_mask[r]);
        end
        if (row_restart[r]) begin
            // these hits are still in the ring when the run stops and must be swept away
            stop_run();
            clear_expected();
            start_run();
            place_trigger(row_fresh[r][23:8], int'(row_fresh[r][7:0]), row_mask[r]);
        end
        for (int a = 0; a < RING; a++) begin
            if (exp_hits[a] != '0) begin
                ev.hit_mask = exp_hits[a];
                ev.addr     = 16'(a);
                exp_q.push_back(ev);
            end
        end
        // readout of address A is fill_start + latency + 1 + A, the FIFO shows it 2 cycles on
        done_cycle = fill_start + int'(row_lat[r]) + last_addr + 6;
        n_take     = exp_q.size();
        drops      = 0;
        if (row_hold[r]) begin
            wait_cycle(done_cycle, 2 * RING);
            drops  = (n_take > FIFO_DEPTH) ? n_take - FIFO_DEPTH : 0;
            n_take = n_take - drops;
            set_ready(row_ready[r], 1'b0);
        end
        for (int i = 0; i < n_take; i++) begin
            wait_event(2 * RING, ev);
            check_event(row_name[r], exp_q[i], ev);
            check_bit({row_name[r], " running in readout"}, 1'b1, running);
        end
        // with ready held low, any event left over after a full lap of the ring stays visible
        set_ready(row_ready[r], 1'b1);
        wait_cycle(fill_start + int'(row_lat[r]) + RING + 4, 2 * RING);
        check_bit({row_name[r], " no extra event"}, 1'b0, event_valid);
        apb_read(trig_pkg::REG_STATUS, rd, err);
        check_word({row_name[r], " drop count"}, 32'(drops), {16'd0, rd[31:16]});
        stop_run();
    endtask

    initial begin
        logic [31:0] rd;
        logic        err;
        runrst      = 1'b1;
        run_start   = 1'b0;
        run_stop    = 1'b0;
        trig_strobe = 1'b0;
        trig_word   = '0;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        paddr       = 8'd0;
        pwdata      = 32'd0;
        event_ready = 1'b0;
        repeat (8) @(posedge sysclk);
        #2;
        check_bit("running in reset", 1'b0, running);
        check_bit("event valid in reset", 1'b0, event_valid);
        check_word("write time in reset", 32'd0, 32'(write_time));
        runrst = 1'b0;

        // the sweep runs first, then the controller settles in idle
        apb_read(trig_pkg::REG_STATUS, rd, err);
        check_state("state after reset", trig_pkg::RUN_CLEAR, trig_pkg::run_state_e'(rd[1:0]));
        wait_state(trig_pkg::RUN_IDLE, RING + 10);
        check_bit("running after sweep", 1'b0, running);
        check_bit("event valid after sweep", 1'b0, event_valid);
        apb_read(trig_pkg::REG_MASK, rd, err);
        check_word("mask reset value", {16'd0, CHAN_ONES}, rd);
        apb_read(trig_pkg::REG_LATENCY, rd, err);
        check_word("latency reset value", 32'h0000_ffff, rd);

        // mask bits of missing channels are not stored
        apb_write(trig_pkg::REG_MASK, 32'h1234_5a3c, err);
        check_bit("mask write error", 1'b0, err);
        apb_read(trig_pkg::REG_MASK, rd, err);
        check_word("mask readback", {16'd0, 16'h5a3c & CHAN_ONES}, rd);
        apb_write(trig_pkg::REG_LATENCY, 32'h0000_0123, err);
        apb_read(trig_pkg::REG_LATENCY, rd, err);
        check_word("latency readback", 32'h0000_0123, rd);
        apb_write(trig_pkg::REG_STATUS, 32'h0000_0002, err);
        check_bit("status write error", 1'b1, err);
        apb_read(8'h0c, rd, err);
        check_bit("unknown offset read error", 1'b1, err);
        apb_write(8'h40, 32'h0000_0001, err);
        check_bit("unknown offset write error", 1'b1, err);
        apb_read(trig_pkg::REG_STATUS, rd, err);
        check_state("state after status write", trig_pkg::RUN_IDLE,
                    trig_pkg::run_state_e'(rd[1:0]));

        for (int r = 0; r < NROWS; r++) begin
            run_row(r);
        end

        if (fail_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- files.f
+incdir+.
trig_pkg.sv
trig_cfg_regs.sv
trig_run_ctrl.sv
trig_channel.sv
trig_event_fifo.sv
trig_process_top.sv
trig_process_tb.sv
